// ==== include/rvpipe_defs.svh ====
`ifndef RVPIPE_DEFS_SVH
`define RVPIPE_DEFS_SVH

// Fetch starts here after reset

`define RVPIPE_RESET_PC 32'h0000_0000

// Width of every data word, address and register value

`define RVPIPE_XLEN 32

// Width of the performance counters
// Both counters saturate at all ones

`define RVPIPE_CNT_W 16

`endif

// ==== design/rvPipePkg.sv ====
`default_nettype none
`include "rvpipe_defs.svh"

package rvPipePkg;

    typedef logic [4:0]               regIdxT;
    typedef logic [`RVPIPE_XLEN-1:0]  wordT;
    typedef logic [31:0]              instrT;
    typedef logic [`RVPIPE_CNT_W-1:0] cntT;

    // Where execute takes an operand from
    typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwdSelT;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} aluOpT;

    // Data bus master states
    typedef enum logic [1:0] {IDLE, BUS, DONE} memStateT;

    // Control bundle produced by decode and carried down the pipe
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  branch;
        logic  aluSrcImm;
        aluOpT aluOp;
        logic  halt;
    } ctrlT;

    typedef struct packed {
        logic   valid;
        ctrlT   ctrl;
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
        wordT   rs1Val;
        wordT   rs2Val;
        wordT   imm;
        wordT   pc;
    } idExT;

    typedef struct packed {
        logic   valid;
        ctrlT   ctrl;
        regIdxT rd;
        wordT   aluResult;
        wordT   storeData;
    } exMemT;

    // Writeback only needs the write enable, the halt marker and the result
    typedef struct packed {
        logic   valid;
        logic   regWrite;
        logic   halt;
        regIdxT rd;
        wordT   result;
    } memWbT;

endpackage

`default_nettype wire

// ==== design/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import rvPipePkg::*; (
    input  regIdxT rs1Dec,
    input  regIdxT rs2Dec,
    input  regIdxT rs1Exec,
    input  regIdxT rs2Exec,
    input  regIdxT rdExec,
    input  regIdxT rdMem,
    input  regIdxT rdWb,
    input  logic   regWriteMem,
    input  logic   regWriteWb,
    input  logic   memReadExec,
    input  logic   branchTaken,
    input  logic   memBusy,
    output fwdSelT fwdA,
    output fwdSelT fwdB,
    output logic   stallFront,
    output logic   flushDecode,
    output logic   flushExec,
    output logic   stallAll
);

    logic loadUse;

    // The memory stage holds the younger result, so it wins over writeback
    // Register zero is never forwarded since it always reads as zero
    function automatic fwdSelT pickFwd(input regIdxT src);
        if (regWriteMem && rdMem != '0 && rdMem == src) begin
            return FWD_MEM;
        end else if (regWriteWb && rdWb != '0 && rdWb == src) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign fwdA = pickFwd(rs1Exec);
    assign fwdB = pickFwd(rs2Exec);

    // A load in execute has no data until it leaves memory
    // A dependent instruction in decode waits one cycle behind a bubble
    assign loadUse = memReadExec && rdExec != '0 &&
                     (rdExec == rs1Dec || rdExec == rs2Dec);

    assign stallFront = loadUse;

    // A taken branch kills the two younger instructions
    // The load-use bubble is inserted by the same execute flush
    assign flushDecode = branchTaken;
    assign flushExec   = branchTaken || loadUse;

    // The whole pipe holds while the data bus is busy
    assign stallAll = memBusy;

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile import rvPipePkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  regIdxT rs1,
    input  regIdxT rs2,
    input  regIdxT rd,
    input  logic   we,
    input  wordT   wd,
    output wordT   rd1,
    output wordT   rd2
);

    wordT regs [32];
    logic wrLive;

    // Entry zero is cleared by reset and never written afterwards
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    assign wrLive = we && rd != '0;

    // Writeback data goes straight to decode in the same cycle
    assign rd1 = (wrLive && rd == rs1) ? wd : regs[rs1];
    assign rd2 = (wrLive && rd == rs2) ? wd : regs[rs2];

endmodule

`default_nettype wire

// ==== design/decodeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeUnit import rvPipePkg::*; (
    input  instrT  instr,
    output regIdxT rs1,
    output regIdxT rs2,
    output regIdxT rd,
    output wordT   imm,
    output ctrlT   ctrl
);

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    wordT       immI;
    wordT       immS;
    wordT       immB;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // Source indices stay zero when a field is unused, so the hazard unit
    // never stalls on immediate bits that only look like a register
    always_comb begin
        rs1  = '0;
        rs2  = '0;
        rd   = '0;
        imm  = '0;
        ctrl = '0;
        case (opcode)
            OP_REG: begin
                ctrl.regWrite = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.aluOp = ALU_ADD;
                    10'b0100000_000: ctrl.aluOp = ALU_SUB;
                    10'b0000000_111: ctrl.aluOp = ALU_AND;
                    10'b0000000_110: ctrl.aluOp = ALU_OR;
                    default:         ctrl.regWrite = 1'b0;
                endcase
                if (ctrl.regWrite) begin
                    rs1 = instr[19:15];
                    rs2 = instr[24:20];
                    rd  = instr[11:7];
                end
            end
            OP_IMM, OP_LOAD: begin
                // ADDI needs funct3 000, LW needs funct3 010
                if (funct3 == (opcode == OP_LOAD ? 3'b010 : 3'b000)) begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.memRead   = (opcode == OP_LOAD);
                    ctrl.aluSrcImm = 1'b1;
                    rs1 = instr[19:15];
                    rd  = instr[11:7];
                    imm = immI;
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b010) begin
                    ctrl.memWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    rs1 = instr[19:15];
                    rs2 = instr[24:20];
                    imm = immS;
                end
            end
            OP_BRANCH: begin
                if (funct3 == 3'b000) begin
                    ctrl.branch = 1'b1;
                    rs1 = instr[19:15];
                    rs2 = instr[24:20];
                    imm = immB;
                end
            end
            OP_SYSTEM: begin
                // Only EBREAK is recognized
                ctrl.halt = (instr == 32'h0010_0073);
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/execUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execUnit import rvPipePkg::*; (
    input  idExT   idEx,
    input  fwdSelT fwdA,
    input  fwdSelT fwdB,
    input  wordT   memResult,
    input  wordT   wbResult,
    output wordT   aluResult,
    output wordT   storeData,
    output wordT   branchTarget,
    output logic   branchTaken
);

    wordT opA;
    wordT opB;
    wordT aluB;

    // Same operand mux for both sources
    function automatic wordT fwdMux(input fwdSelT sel, input wordT rfVal);
        case (sel)
            FWD_MEM: return memResult;
            FWD_WB:  return wbResult;
            default: return rfVal;
        endcase
    endfunction

    assign opA = fwdMux(fwdA, idEx.rs1Val);
    assign opB = fwdMux(fwdB, idEx.rs2Val);

    // Loads and stores add the immediate to form the address
    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            ALU_SUB: aluResult = opA - aluB;
            ALU_AND: aluResult = opA & aluB;
            ALU_OR:  aluResult = opA | aluB;
            default: aluResult = opA + aluB;
        endcase
    end

    // Store data also needs the forwarded value of rs2
    assign storeData = opB;

    assign branchTarget = idEx.pc + idEx.imm;
    assign branchTaken  = idEx.valid && idEx.ctrl.branch && (opA == opB);

endmodule

`default_nettype wire

// ==== design/memAccessFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module memAccessFsm import rvPipePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  exMemT      exMem,
    input  wordT       wbDatR,
    input  logic       wbAck,
    output logic       memBusy,
    output wordT       loadData,
    output logic       wbCyc,
    output logic       wbStb,
    output logic       wbWe,
    output wordT       wbAdr,
    output wordT       wbDatW,
    output logic [3:0] wbSel
);

    memStateT state;
    memStateT stateNext;
    logic     memReq;

    assign memReq = exMem.valid && (exMem.ctrl.memRead || exMem.ctrl.memWrite);

    // DONE lasts one cycle, the pipe moves on and the request leaves exMem
    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (memReq) begin
                    stateNext = BUS;
                end
            end
            BUS: begin
                if (wbAck) begin
                    stateNext = DONE;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk) begin
        if (state == BUS && wbAck) begin
            loadData <= wbDatR;
        end
    end

    // The request is seen in IDLE already, so the freeze starts at once
    assign memBusy = (state == IDLE && memReq) || state == BUS;

    // exMem is frozen for the whole cycle, which keeps the bus steady
    assign wbCyc  = (state == BUS);
    assign wbStb  = (state == BUS);
    assign wbWe   = (state == BUS) && exMem.ctrl.memWrite;
    assign wbAdr  = exMem.aluResult;
    assign wbDatW = exMem.storeData;
    assign wbSel  = 4'hF;

endmodule

`default_nettype wire

// ==== design/perfCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module perfCounter import rvPipePkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic retire,
    input  logic bubble,
    output cntT  retireCount,
    output cntT  bubbleCount
);

    // Both counters stick at all ones rather than wrap
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retireCount <= '0;
            bubbleCount <= '0;
        end else begin
            if (retire && retireCount != '1) begin
                retireCount <= retireCount + 1'b1;
            end
            if (bubble && bubbleCount != '1) begin
                bubbleCount <= bubbleCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/rvPipeTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvpipe_defs.svh"

module rvPipeTop import rvPipePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  instrT      instrData,
    input  wordT       wbDatR,
    input  logic       wbAck,
    output wordT       instrAddr,
    output logic       wbCyc,
    output logic       wbStb,
    output logic       wbWe,
    output wordT       wbAdr,
    output wordT       wbDatW,
    output logic [3:0] wbSel,
    output logic       halted,
    output cntT        retireCount,
    output cntT        bubbleCount
);

    wordT   pc;
    wordT   ifIdPc;
    instrT  ifIdInstr;
    logic   ifIdValid;
    idExT   idEx;
    idExT   idExNext;
    exMemT  exMem;
    memWbT  memWb;
    regIdxT decRs1, decRs2, decRd;
    wordT   decImm, rd1, rd2, loadData, memResult;
    wordT   aluResult, storeData, branchTarget;
    ctrlT   decCtrl;
    fwdSelT fwdA, fwdB;
    logic   stallFront, flushDecode, flushExec, stallAll;
    logic   branchTaken, memBusy, haltSeen, fetchHalt, haltDone;

    assign instrAddr = pc;

    // Fetch stops behind a decoded EBREAK and stays stopped
    assign fetchHalt = haltSeen || (ifIdValid && decCtrl.halt);

    // PC and IF/ID control; a redirect wins over the load-use hold
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc        <= `RVPIPE_RESET_PC;
            ifIdValid <= 1'b0;
            haltSeen  <= 1'b0;
        end else if (!stallAll) begin
            if (flushDecode) begin
                pc        <= branchTarget;
                ifIdValid <= 1'b0;
            end else if (!stallFront) begin
                if (fetchHalt) begin
                    ifIdValid <= 1'b0;
                    haltSeen  <= 1'b1;
                end else begin
                    pc        <= pc + 32'd4;
                    ifIdValid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stallAll && !flushDecode && !stallFront && !fetchHalt) begin
            ifIdPc    <= pc;
            ifIdInstr <= instrData;
        end
    end

    decodeUnit decodeUnit_i (.instr(ifIdInstr), .rs1(decRs1), .rs2(decRs2), .rd(decRd),
                             .imm(decImm), .ctrl(decCtrl));

    regFile regFile_i (.clk(clk), .rstN(rstN), .rs1(decRs1), .rs2(decRs2), .rd(memWb.rd),
                       .we(memWb.valid && memWb.regWrite), .wd(memWb.result),
                       .rd1(rd1), .rd2(rd2));

    // An empty decode slot carries no control and no sources
    always_comb begin
        idExNext.valid  = ifIdValid;
        idExNext.ctrl   = ifIdValid ? decCtrl : '0;
        idExNext.rs1    = ifIdValid ? decRs1 : '0;
        idExNext.rs2    = ifIdValid ? decRs2 : '0;
        idExNext.rd     = decRd;
        idExNext.rs1Val = rd1;
        idExNext.rs2Val = rd2;
        idExNext.imm    = decImm;
        idExNext.pc     = ifIdPc;
    end

    hazardUnit hazardUnit_i (
        .rs1Dec(idExNext.rs1), .rs2Dec(idExNext.rs2), .rs1Exec(idEx.rs1), .rs2Exec(idEx.rs2),
        .rdExec(idEx.rd), .rdMem(exMem.rd), .rdWb(memWb.rd),
        .regWriteMem(exMem.valid && exMem.ctrl.regWrite),
        .regWriteWb(memWb.valid && memWb.regWrite),
        .memReadExec(idEx.valid && idEx.ctrl.memRead), .branchTaken(branchTaken),
        .memBusy(memBusy), .fwdA(fwdA), .fwdB(fwdB), .stallFront(stallFront),
        .flushDecode(flushDecode), .flushExec(flushExec), .stallAll(stallAll));

    execUnit execUnit_i (.idEx(idEx), .fwdA(fwdA), .fwdB(fwdB), .memResult(memResult),
                         .wbResult(memWb.result), .aluResult(aluResult),
                         .storeData(storeData), .branchTarget(branchTarget),
                         .branchTaken(branchTaken));

    memAccessFsm memAccessFsm_i (.clk(clk), .rstN(rstN), .exMem(exMem), .wbDatR(wbDatR),
                                 .wbAck(wbAck), .memBusy(memBusy), .loadData(loadData),
                                 .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
                                 .wbDatW(wbDatW), .wbSel(wbSel));

    assign memResult = exMem.ctrl.memRead ? loadData : exMem.aluResult;

    // Every pipeline register holds while the bus is busy
    // A flush of execute leaves a bubble with all control low
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx  <= '0;
            exMem <= '0;
            memWb <= '0;
        end else if (!stallAll) begin
            idEx            <= flushExec ? '0 : idExNext;
            exMem.valid     <= idEx.valid;
            exMem.ctrl      <= idEx.ctrl;
            exMem.rd        <= idEx.rd;
            exMem.aluResult <= aluResult;
            exMem.storeData <= storeData;
            memWb.valid     <= exMem.valid;
            memWb.regWrite  <= exMem.ctrl.regWrite;
            memWb.halt      <= exMem.ctrl.halt;
            memWb.rd        <= exMem.rd;
            memWb.result    <= memResult;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            haltDone <= 1'b0;
        end else if (memWb.valid && memWb.halt) begin
            haltDone <= 1'b1;
        end
    end

    assign halted = haltDone || (memWb.valid && memWb.halt);

    // A frozen writeback slot is counted once, on the cycle it moves on
    perfCounter perfCounter_i (.clk(clk), .rstN(rstN), .retire(memWb.valid && !stallAll),
                               .bubble(stallFront && !stallAll),
                               .retireCount(retireCount), .bubbleCount(bubbleCount));

endmodule

`default_nettype wire

// ==== tb/rvPipeTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvpipe_defs.svh"

module rvPipeTb import rvPipePkg::*; ();

    logic       clk;
    logic       rstN;
    instrT      instrData;
    wordT       wbDatR;
    logic       wbAck;
    wordT       instrAddr;
    logic       wbCyc;
    logic       wbStb;
    logic       wbWe;
    wordT       wbAdr;
    wordT       wbDatW;
    logic [3:0] wbSel;
    logic       halted;
    cntT        retireCount;
    cntT        bubbleCount;

    // The raw stimulus words come first and the sections unpacked from them follow
    logic [31:0] stim [0:127];
    instrT       prog [0:63];
    wordT        dataMem [0:63];
    wordT        expAdr [$];
    wordT        expDat [$];
    cntT         expRetire;
    cntT         expBubble;
    int          progLen;
    int          storeSeen;
    int          errCount;
    int          testCount;
    int          badTests;
    int          cycleLimit;
    int          cycles;
    int          mainErrBefore;
    logic        reqOpen;
    int          waitLeft;
    logic [31:0] rngState;

    rvPipeTop rvPipeTop_i (
        .clk(clk), .rstN(rstN), .instrData(instrData), .wbDatR(wbDatR), .wbAck(wbAck),
        .instrAddr(instrAddr), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbSel(wbSel), .halted(halted), .retireCount(retireCount),
        .bubbleCount(bubbleCount));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // The instruction ROM is combinational and addresses past the program read as a NOP
    assign instrData = (instrAddr[31:2] < progLen) ? prog[instrAddr[7:2]] : 32'h0000_0013;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkCount(input string name, input cntT got, input cntT exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkSel(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errCount++;
        end
    endtask

    // Prints one line per finished test and marks it bad if it raised any error
    task automatic endTest(input string name, input int errBefore);
        testCount++;
        if (errCount == errBefore) begin
            $display("%-24s ok", name);
        end else begin
            badTests++;
            $display("%-24s FAIL", name);
        end
    endtask

    // File layout is length, program, store count, address and data pairs, counts
    task automatic readStim();
        int i;
        int pos;
        int nStores;
        $readmemh("tb/rvPipeStim.txt", stim);
        progLen = stim[0];
        if (progLen <= 0 || progLen > 64) begin
            $display("Stimulus file is missing or its program length is out of range");
            errCount++;
            progLen = 0;
        end
        for (i = 0; i < progLen; i++) begin
            prog[i] = stim[1 + i];
        end
        pos = 1 + progLen;
        nStores = stim[pos];
        pos++;
        for (i = 0; i < nStores; i++) begin
            expAdr.push_back(stim[pos]);
            expDat.push_back(stim[pos + 1]);
            pos += 2;
        end
        expRetire = cntT'(stim[pos]);
        expBubble = cntT'(stim[pos + 1]);
    endtask

    // Wishbone slave with 0 to 3 wait cycles per request
    // Ack lasts one cycle and the master drops cyc right after it
    always @(posedge clk) begin : wbSlave
        int idx;
        int errBefore;
        #1;
        if (!rstN) begin
            wbAck   = 1'b0;
            reqOpen = 1'b0;
        end else if (wbAck) begin
            wbAck = 1'b0;
        end else if (wbCyc && wbStb) begin
            if (!reqOpen) begin
                reqOpen  = 1'b1;
                rngState = xorshift32(rngState);
                waitLeft = rngState[1:0];
            end
            if (waitLeft == 0) begin
                reqOpen = 1'b0;
                idx = wbAdr[7:2];
                errBefore = errCount;
                if (wbAdr > 32'hFF || wbAdr[1:0] != 2'b00) begin
                    $display("Bus access at %0t to %h falls outside the memory", $time, wbAdr);
                    errCount++;
                end
                // Every access uses all four byte lanes
                checkSel("wbSel", wbSel, 4'hF);
                if (wbWe) begin
                    if (storeSeen < expAdr.size()) begin
                        checkWord("wbAdr", wbAdr, expAdr[storeSeen]);
                        checkWord("wbDatW", wbDatW, expDat[storeSeen]);
                        endTest($sformatf("store %0d", storeSeen), errBefore);
                    end else begin
                        $display("Unexpected write of %h to %h at %0t after all stores",
                                 wbDatW, wbAdr, $time);
                        errCount++;
                    end
                    storeSeen++;
                    dataMem[idx] = wbDatW;
                end else begin
                    wbDatR = dataMem[idx];
                end
                wbAck = 1'b1;
            end else begin
                waitLeft--;
            end
        end
    end

    initial begin
        rstN      = 1'b0;
        wbAck     = 1'b0;
        wbDatR    = '0;
        reqOpen   = 1'b0;
        waitLeft  = 0;
        rngState  = 32'd84644;
        progLen   = 0;
        storeSeen = 0;
        errCount  = 0;
        testCount = 0;
        badTests  = 0;
        readStim();
        // Every word holds a value derived from its own address
        for (int i = 0; i < 64; i++) begin
            dataMem[i] = 32'hC0DE_0000 | (i << 2);
        end
        cycleLimit = 4 * (progLen + 8) * 4;
        repeat (8) @(posedge clk);
        #1;
        // While reset is held the PC sits at the reset address and the bus is idle
        mainErrBefore = errCount;
        checkWord("instrAddr", instrAddr, `RVPIPE_RESET_PC);
        checkBit("wbCyc", wbCyc, 1'b0);
        checkBit("wbStb", wbStb, 1'b0);
        checkBit("wbWe", wbWe, 1'b0);
        checkBit("halted", halted, 1'b0);
        checkCount("retireCount", retireCount, '0);
        checkCount("bubbleCount", bubbleCount, '0);
        endTest("reset state", mainErrBefore);
        rstN = 1'b1;
        cycles = 0;
        while (!halted && cycles < cycleLimit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: halted did not rise within %0d cycles", cycleLimit);
            $display("test failed");
            $finish;
        end else begin
            // After the halt the bus stays idle and halted stays high
            mainErrBefore = errCount;
            repeat (20) begin
                @(posedge clk);
                #1;
                if (wbCyc) begin
                    $display("Bus cycle to %h started at %0t after the halt", wbAdr, $time);
                    errCount++;
                end
                if (!halted) begin
                    $display("Halted dropped at %0t", $time);
                    errCount++;
                end
            end
            endTest("halt", mainErrBefore);
            mainErrBefore = errCount;
            if (storeSeen != expAdr.size()) begin
                $display("Only %0d of %0d expected stores appeared", storeSeen, expAdr.size());
                errCount++;
            end
            endTest("store count", mainErrBefore);
            mainErrBefore = errCount;
            checkCount("retireCount", retireCount, expRetire);
            endTest("retire count", mainErrBefore);
            mainErrBefore = errCount;
            checkCount("bubbleCount", bubbleCount, expBubble);
            endTest("bubble count", mainErrBefore);
            $display("%0d tests run, %0d with errors, %0d errors in total",
                     testCount, badTests, errCount);
            if (errCount == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb/rvPipeStim.txt ====
// Word count, program words, store count, store address and data, retire, bubbles
// All values are hex
17
00700093
00608113
002081B3
40118233
0021F2B3
00326333
04602023
04502223
04402423
04002383
00338413
04802823
08002483
00148533
04A02A23
00220663
04102C23
04202E23
00208463
06302023
00500013
06002223
00100073
// Stores in bus order, address then data
7
00000040 0000001D
00000044 00000004
00000048 0000000D
00000050 00000020
00000054 C0DE0087
00000060 00000014
00000064 00000000
// Retired instructions, then load-use bubbles
15
2

// ==== rvPipe.f ====
+incdir+include
design/rvPipePkg.sv
design/hazardUnit.sv
design/regFile.sv
design/decodeUnit.sv
design/execUnit.sv
design/memAccessFsm.sv
design/perfCounter.sv
design/rvPipeTop.sv
tb/rvPipeTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rvPipeTb
RTL_TOP   ?= rvPipeTop
FILELIST  ?= rvPipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+include design/*.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
